/* design/adc_front.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_front (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // raw converter words
  input  logic [cal_pkg::CHN-1:0][cal_pkg::ADC_RAW_W-1:0] adc_dat_i,
  // calibrated DAC samples for loopback
  input  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0]     lpb_i,
  cal_cfg_if.adc                                        cfg,
  output logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0]     adc_cal_o
);

  // captured samples, two's complement
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] raw_q;
  // calibration input after loopback mux
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] src;

  ////////////////////////////////////////
  // capture and format conversion
  ////////////////////////////////////////

  // top bit kept, next 13 inverted
  // two lsbs dropped
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      for (int i = 0; i < cal_pkg::CHN; i++) begin
        raw_q[i] <= {adc_dat_i[i][cal_pkg::ADC_RAW_W-1],
                     ~adc_dat_i[i][cal_pkg::ADC_RAW_W-2:cal_pkg::ADC_RAW_W-cal_pkg::SMP_W]};
      end
    end
  end

  // loopback select, no register here
  always_comb begin
    for (int i = 0; i < cal_pkg::CHN; i++) begin
      src[i] = cfg.loop[i] ? lpb_i[i] : raw_q[i];
    end
  end

  // gain and offset per channel
  for (genvar i = 0; i < cal_pkg::CHN; i++) begin : g_ch
    linear_cal cal_adc (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (src[i]),
      .mul_i   (cfg.adc_mul[i]),
      .sum_i   (cfg.adc_sum[i]),
      .dat_o   (adc_cal_o[i])
    );
  end

endmodule

`default_nettype wire

/* design/analog_top.sv */
`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  logic                                          adc_clk,
  input  logic                                          top_rst,
  // converter and generator streams
  input  logic [cal_pkg::CHN-1:0][cal_pkg::ADC_RAW_W-1:0] adc_dat_i,
  input  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0]     gen_dat_i,
  // host register port
  input  logic                                          req_i,
  input  logic                                          we_i,
  input  logic [cal_pkg::ADDR_W-1:0]                    addr_i,
  input  logic [cal_pkg::DATA_W-1:0]                    wdata_i,
  output logic                                          ack_o,
  output logic [cal_pkg::DATA_W-1:0]                    rdata_o,
  // calibrated outputs
  output logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0]     adc_cal_o,
  output logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0]     dac_dat_o
);

  // calibration words and loop selects
  cal_cfg_if cfg ();

  // digital loopback, DAC side to ADC side
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] lpb;

  cal_regs regs_i (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .ack_o   (ack_o),
    .rdata_o (rdata_o),
    .cfg     (cfg)
  );

  adc_front adc_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .lpb_i     (lpb),
    .cfg       (cfg),
    .adc_cal_o (adc_cal_o)
  );

  dac_back dac_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .cfg       (cfg),
    .lpb_o     (lpb),
    .dac_dat_o (dac_dat_o)
  );

endmodule

`default_nettype wire

/* design/cal_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cal_cfg_if;

  // ADC side calibration
  logic [cal_pkg::CHN-1:0][cal_pkg::MUL_W-1:0] adc_mul;
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] adc_sum;
  // DAC side calibration
  logic [cal_pkg::CHN-1:0][cal_pkg::MUL_W-1:0] dac_mul;
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] dac_sum;
  // digital loopback select per channel
  logic [cal_pkg::CHN-1:0]                     loop;

  // register block owns every word
  modport regs (output adc_mul, adc_sum, dac_mul, dac_sum, loop);
  // acquisition path
  modport adc (input adc_mul, adc_sum, loop);
  // generation path
  modport dac (input dac_mul, dac_sum);

endinterface

`default_nettype wire

/* design/cal_pkg.sv */
`default_nettype none

package cal_pkg;

  ////////////////////////////////////////
  // datapath geometry
  ////////////////////////////////////////

  // two analog channels
  localparam int CHN = 2;
  // raw ADC word, two lowest bits unused
  localparam int ADC_RAW_W = 16;
  // signed sample on both sides
  localparam int SMP_W = 14;
  // signed gain word
  localparam int MUL_W = 16;
  // gain fixed point position
  localparam int CAL_SHIFT = 13;
  // full product of sample and gain
  localparam int PRD_W = SMP_W + MUL_W;

  // gain of 1.0
  localparam logic [MUL_W-1:0] CAL_ONE = MUL_W'(1) << CAL_SHIFT;

  // clip limits, product width for direct compare
  localparam logic signed [PRD_W-1:0] SMP_MAX = PRD_W'(2 ** (SMP_W - 1) - 1);
  localparam logic signed [PRD_W-1:0] SMP_MIN = PRD_W'(-(2 ** (SMP_W - 1)));

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam int ADDR_W = 4;
  localparam int DATA_W = 16;

  localparam logic [ADDR_W-1:0] REG_ADC_MUL0 = 4'd0;
  localparam logic [ADDR_W-1:0] REG_ADC_MUL1 = 4'd1;
  localparam logic [ADDR_W-1:0] REG_ADC_SUM0 = 4'd2;
  localparam logic [ADDR_W-1:0] REG_ADC_SUM1 = 4'd3;
  localparam logic [ADDR_W-1:0] REG_DAC_MUL0 = 4'd4;
  localparam logic [ADDR_W-1:0] REG_DAC_MUL1 = 4'd5;
  localparam logic [ADDR_W-1:0] REG_DAC_SUM0 = 4'd6;
  localparam logic [ADDR_W-1:0] REG_DAC_SUM1 = 4'd7;
  // bit i enables loopback on channel i
  localparam logic [ADDR_W-1:0] REG_LOOP     = 4'd8;

endpackage

`default_nettype wire

/* design/cal_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cal_regs (
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // host port, four-phase req/ack
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [cal_pkg::ADDR_W-1:0]   addr_i,
  input  logic [cal_pkg::DATA_W-1:0]   wdata_i,
  output logic                         ack_o,
  output logic [cal_pkg::DATA_W-1:0]   rdata_o,
  // configuration toward datapaths
  cal_cfg_if.regs                      cfg
);

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  logic [cal_pkg::CHN-1:0][cal_pkg::MUL_W-1:0] adc_mul_q;
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] adc_sum_q;
  logic [cal_pkg::CHN-1:0][cal_pkg::MUL_W-1:0] dac_mul_q;
  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] dac_sum_q;
  logic [cal_pkg::CHN-1:0]                     loop_q;

  // request seen, not yet acknowledged
  logic                       req_new;
  logic [cal_pkg::DATA_W-1:0] rd_val;

  assign req_new = req_i & ~ack_o;

  // read mux, unmapped reads as zero
  // offsets and loop zero-extended
  always_comb begin
    rd_val = '0;
    case (addr_i)
      cal_pkg::REG_ADC_MUL0: rd_val = adc_mul_q[0];
      cal_pkg::REG_ADC_MUL1: rd_val = adc_mul_q[1];
      cal_pkg::REG_ADC_SUM0: rd_val = {{(cal_pkg::DATA_W-cal_pkg::SMP_W){1'b0}}, adc_sum_q[0]};
      cal_pkg::REG_ADC_SUM1: rd_val = {{(cal_pkg::DATA_W-cal_pkg::SMP_W){1'b0}}, adc_sum_q[1]};
      cal_pkg::REG_DAC_MUL0: rd_val = dac_mul_q[0];
      cal_pkg::REG_DAC_MUL1: rd_val = dac_mul_q[1];
      cal_pkg::REG_DAC_SUM0: rd_val = {{(cal_pkg::DATA_W-cal_pkg::SMP_W){1'b0}}, dac_sum_q[0]};
      cal_pkg::REG_DAC_SUM1: rd_val = {{(cal_pkg::DATA_W-cal_pkg::SMP_W){1'b0}}, dac_sum_q[1]};
      cal_pkg::REG_LOOP:     rd_val = {{(cal_pkg::DATA_W-cal_pkg::CHN){1'b0}}, loop_q};
      default:               rd_val = '0;
    endcase
  end

  ////////////////////////////////////////
  // handshake and register update
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      ack_o     <= 1'b0;
      rdata_o   <= '0;
      // unity gain, no offset, no loopback
      adc_mul_q <= {cal_pkg::CHN{cal_pkg::CAL_ONE}};
      dac_mul_q <= {cal_pkg::CHN{cal_pkg::CAL_ONE}};
      adc_sum_q <= '0;
      dac_sum_q <= '0;
      loop_q    <= '0;
    end else if (req_new) begin
      // ack rises on the access edge
      ack_o <= 1'b1;
      if (we_i) begin
        case (addr_i)
          cal_pkg::REG_ADC_MUL0: adc_mul_q[0] <= wdata_i;
          cal_pkg::REG_ADC_MUL1: adc_mul_q[1] <= wdata_i;
          cal_pkg::REG_ADC_SUM0: adc_sum_q[0] <= wdata_i[cal_pkg::SMP_W-1:0];
          cal_pkg::REG_ADC_SUM1: adc_sum_q[1] <= wdata_i[cal_pkg::SMP_W-1:0];
          cal_pkg::REG_DAC_MUL0: dac_mul_q[0] <= wdata_i;
          cal_pkg::REG_DAC_MUL1: dac_mul_q[1] <= wdata_i;
          cal_pkg::REG_DAC_SUM0: dac_sum_q[0] <= wdata_i[cal_pkg::SMP_W-1:0];
          cal_pkg::REG_DAC_SUM1: dac_sum_q[1] <= wdata_i[cal_pkg::SMP_W-1:0];
          cal_pkg::REG_LOOP:     loop_q       <= wdata_i[cal_pkg::CHN-1:0];
          default:               ;
        endcase
      end else begin
        rdata_o <= rd_val;
      end
    end else if (!req_i) begin
      // host released, close the cycle
      ack_o <= 1'b0;
    end
  end

  // datapaths see the registers directly
  assign cfg.adc_mul = adc_mul_q;
  assign cfg.adc_sum = adc_sum_q;
  assign cfg.dac_mul = dac_mul_q;
  assign cfg.dac_sum = dac_sum_q;
  assign cfg.loop    = loop_q;

endmodule

`default_nettype wire

/* design/dac_back.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_back (
  input  logic                                      adc_clk,
  input  logic                                      top_rst,
  // generator samples, signed
  input  logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] gen_dat_i,
  cal_cfg_if.dac                                    cfg,
  // calibrated samples toward the ADC side
  output logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] lpb_o,
  // DAC words, inverted offset binary
  output logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] dac_dat_o
);

  ////////////////////////////////////////
  // calibration
  ////////////////////////////////////////

  // one gain/offset stage per channel
  for (genvar i = 0; i < cal_pkg::CHN; i++) begin : g_ch
    linear_cal cal_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (gen_dat_i[i]),
      .mul_i   (cfg.dac_mul[i]),
      .sum_i   (cfg.dac_sum[i]),
      .dat_o   (lpb_o[i])
    );
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // sign kept, magnitude bits inverted
  // gives the negative slope the DAC expects
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else begin
      for (int i = 0; i < cal_pkg::CHN; i++) begin
        dac_dat_o[i] <= {lpb_o[i][cal_pkg::SMP_W-1], ~lpb_o[i][cal_pkg::SMP_W-2:0]};
      end
    end
  end

endmodule

`default_nettype wire

/* design/linear_cal.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_cal (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  input  logic signed [cal_pkg::SMP_W-1:0]  dat_i,
  input  logic signed [cal_pkg::MUL_W-1:0]  mul_i,
  input  logic signed [cal_pkg::SMP_W-1:0]  sum_i,
  output logic signed [cal_pkg::SMP_W-1:0]  dat_o
);

  // operands widened to product width
  logic signed [cal_pkg::PRD_W-1:0] dat_x;
  logic signed [cal_pkg::PRD_W-1:0] mul_x;
  logic signed [cal_pkg::PRD_W-1:0] sum_x;
  // stage one product
  logic signed [cal_pkg::PRD_W-1:0] prd_q;
  // stage two terms
  logic signed [cal_pkg::PRD_W-1:0] prd_sh;
  logic signed [cal_pkg::PRD_W-1:0] acc;
  logic signed [cal_pkg::PRD_W-1:0] sat;

  assign dat_x = {{cal_pkg::MUL_W{dat_i[cal_pkg::SMP_W-1]}}, dat_i};
  assign mul_x = {{cal_pkg::SMP_W{mul_i[cal_pkg::MUL_W-1]}}, mul_i};
  assign sum_x = {{(cal_pkg::PRD_W-cal_pkg::SMP_W){sum_i[cal_pkg::SMP_W-1]}}, sum_i};

  ////////////////////////////////////////
  // stage one, full product
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prd_q <= '0;
    end else begin
      prd_q <= dat_x * mul_x;
    end
  end

  ////////////////////////////////////////
  // stage two, scale, offset, clip
  ////////////////////////////////////////

  // drop fraction bits of the gain
  assign prd_sh = prd_q >>> cal_pkg::CAL_SHIFT;
  // offset uses the live register value
  assign acc    = prd_sh + sum_x;

  always_comb begin
    if (acc > cal_pkg::SMP_MAX) begin
      sat = cal_pkg::SMP_MAX;
    end else if (acc < cal_pkg::SMP_MIN) begin
      sat = cal_pkg::SMP_MIN;
    end else begin
      sat = acc;
    end
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat[cal_pkg::SMP_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* dv/analog_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module analog_tb;

  typedef logic [cal_pkg::CHN-1:0][cal_pkg::SMP_W-1:0] pair_t;

  // edges allowed per handshake phase
  localparam int ACK_LIMIT = 16;
  // the 13 bits inverted by both format changes
  localparam logic [cal_pkg::SMP_W-1:0] MAG = {1'b0, {(cal_pkg::SMP_W-1){1'b1}}};
  localparam longint LIM = longint'(1) << (cal_pkg::SMP_W - 1);

  logic                                            adc_clk;
  logic                                            top_rst;
  logic [cal_pkg::CHN-1:0][cal_pkg::ADC_RAW_W-1:0] adc_dat_i;
  pair_t                                           gen_dat_i;
  logic                                            req_i;
  logic                                            we_i;
  logic [cal_pkg::ADDR_W-1:0]                      addr_i;
  logic [cal_pkg::DATA_W-1:0]                      wdata_i;
  logic                                            ack_o;
  logic [cal_pkg::DATA_W-1:0]                      rdata_o;
  pair_t                                           adc_cal_o;
  pair_t                                           dac_dat_o;

  // register shadow by address
  // unmapped entries stay zero
  logic [cal_pkg::DATA_W-1:0] shadow [16];
  // expected outputs 3 and 4 edges deep
  pair_t q_adc[$];
  pair_t q_dac[$];
  pair_t q_lpb[$];
  int    seed;
  int    sat_hi;
  int    sat_lo;

  analog_top dut_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [cal_pkg::DATA_W-1:0] rnd16();
    int r;
    r = $random(seed);
    return r[cal_pkg::DATA_W-1:0];
  endfunction

  // bits kept by each register
  // gains sit where address bit 1 is clear
  function automatic logic [cal_pkg::DATA_W-1:0] reg_mask(logic [cal_pkg::ADDR_W-1:0] a);
    if (a > cal_pkg::REG_LOOP) return '0;
    if (a == cal_pkg::REG_LOOP) return cal_pkg::DATA_W'((1 << cal_pkg::CHN) - 1);
    if (a[1]) return cal_pkg::DATA_W'((1 << cal_pkg::SMP_W) - 1);
    return '1;
  endfunction

  // x * gain / 2^13 + offset clipped to 14 bits signed
  function automatic logic [cal_pkg::SMP_W-1:0] cal_ref(
    input logic [cal_pkg::SMP_W-1:0] x,
    input logic [cal_pkg::MUL_W-1:0] m,
    input logic [cal_pkg::SMP_W-1:0] s
  );
    longint v;
    v = longint'($signed(x)) * longint'($signed(m));
    v = (v >>> cal_pkg::CAL_SHIFT) + longint'($signed(s));
    if (v > LIM - 1) begin
      v = LIM - 1;
    end else if (v < -LIM) begin
      v = -LIM;
    end
    return v[cal_pkg::SMP_W-1:0];
  endfunction

  task automatic give_up(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // host bus driver
  ////////////////////////////////////////

  // entered and left 2 ns after an edge
  task automatic host_cycle(input logic wr, input logic [3:0] a, input logic [15:0] d);
    int n;
    req_i   = 1'b1;
    we_i    = wr;
    addr_i  = a;
    wdata_i = d;
    n = 0;
    do begin
      @(posedge adc_clk);
      #1;
      n++;
      if (n > ACK_LIMIT) give_up("timeout: ack_o did not rise after req_i");
    end while (!ack_o);
    // rdata valid while ack is high
    if (wr) shadow[a] = d & reg_mask(a);
    else check($sformatf("rdata_o @%0d", a), shadow[a], rdata_o);
    #1;
    req_i = 1'b0;
    n = 0;
    do begin
      @(posedge adc_clk);
      #1;
      n++;
      if (n > ACK_LIMIT) give_up("timeout: ack_o did not fall after req_i dropped");
    end while (ack_o);
    #1;
  endtask

  // random offsets and gains masked by gmask
  task automatic randomize_cal(input logic [15:0] gmask);
    for (int a = 0; a < 8; a++) begin
      host_cycle(1'b1, 4'(a), rnd16() & ((reg_mask(4'(a)) == '1) ? gmask : '1));
    end
  endtask

  ////////////////////////////////////////
  // random streams against the model
  ////////////////////////////////////////

  task automatic stream(input int n);
    pair_t ea;
    pair_t ed;
    pair_t el;
    pair_t pa;
    pair_t pd;
    pair_t pl;
    logic [15:0] r;
    logic [15:0] amul;
    logic [15:0] asum;
    logic [cal_pkg::SMP_W-1:0] dv;
    q_adc.delete();
    q_dac.delete();
    q_lpb.delete();
    for (int c = 0; c < n; c++) begin
      @(posedge adc_clk);
      #1;
      // compare only after 5 edges of fixed config
      if (q_adc.size() == 3) begin
        pa = q_adc.pop_front();
        pd = q_dac.pop_front();
        for (int ch = 0; ch < cal_pkg::CHN; ch++) begin
          if (c >= 5) begin
            check($sformatf("dac_dat_o[%0d]", ch), 16'(pd[ch]), 16'(dac_dat_o[ch]));
            if (!shadow[cal_pkg::REG_LOOP][ch]) begin
              check($sformatf("adc_cal_o[%0d]", ch), 16'(pa[ch]), 16'(adc_cal_o[ch]));
              // compared results sitting on a limit
              if (pa[ch] == cal_pkg::SMP_W'(LIM - 1))
                sat_hi++;
              if (pa[ch] == cal_pkg::SMP_W'(-LIM))
                sat_lo++;
            end
          end
        end
      end
      if (q_lpb.size() == 4) begin
        pl = q_lpb.pop_front();
        for (int ch = 0; ch < cal_pkg::CHN; ch++) begin
          if (c >= 5 && shadow[cal_pkg::REG_LOOP][ch])
            check($sformatf("adc_cal_o[%0d] loop", ch), 16'(pl[ch]), 16'(adc_cal_o[ch]));
        end
      end
      #1;
      for (int ch = 0; ch < cal_pkg::CHN; ch++) begin
        adc_dat_i[ch] = rnd16();
        r = rnd16();
        gen_dat_i[ch] = r[cal_pkg::SMP_W-1:0];
        amul = shadow[4'(ch) + cal_pkg::REG_ADC_MUL0];
        asum = shadow[4'(ch) + cal_pkg::REG_ADC_SUM0];
        // raw word loses 2 lsbs and all but the sign are inverted
        ea[ch] = cal_ref(adc_dat_i[ch][15:2] ^ MAG, amul, asum[cal_pkg::SMP_W-1:0]);
        r = shadow[4'(ch) + cal_pkg::REG_DAC_SUM0];
        dv = cal_ref(gen_dat_i[ch], shadow[4'(ch) + cal_pkg::REG_DAC_MUL0],
                     r[cal_pkg::SMP_W-1:0]);
        ed[ch] = dv ^ MAG;
        el[ch] = cal_ref(dv, amul, asum[cal_pkg::SMP_W-1:0]);
      end
      q_adc.push_back(ea);
      q_dac.push_back(ed);
      q_lpb.push_back(el);
    end
  endtask

  initial begin
    seed      = 32'h40ca;
    top_rst   = 1'b1;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    adc_dat_i = '0;
    gen_dat_i = '0;
    sat_hi    = 0;
    sat_lo    = 0;
    // gains reset to unity and all else to zero
    for (int a = 0; a < 16; a++)
      shadow[a] = (reg_mask(4'(a)) == '1) ? cal_pkg::CAL_ONE : '0;
    repeat (4) @(posedge adc_clk);
    #2;
    top_rst = 1'b0;
    for (int a = 0; a < 16; a++)
      host_cycle(1'b0, 4'(a), '0);
    stream(40);
    // full map write and readback including unmapped
    repeat (2) begin
      for (int a = 0; a < 16; a++)
        host_cycle(1'b1, 4'(a), rnd16());
      for (int a = 0; a < 16; a++)
        host_cycle(1'b0, 4'(a), '0);
    end
    host_cycle(1'b1, cal_pkg::REG_LOOP, '0);
    randomize_cal(16'h3fff);
    stream(100);
    // large gains drive both limits
    randomize_cal(16'hffff);
    stream(200);
    assert (sat_hi > 0 && sat_lo > 0) else give_up("adc_cal_o never reached both saturation limits");
    // loopback one channel at a time
    host_cycle(1'b1, cal_pkg::REG_LOOP, 16'h0001);
    stream(100);
    randomize_cal(16'h7fff);
    host_cycle(1'b1, cal_pkg::REG_LOOP, 16'h0002);
    stream(100);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/cal_regs_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cal_regs_sva (
  input logic adc_clk,
  input logic top_rst,
  input logic req_i,
  input logic ack_o
);

  // ack only answers a pending request
  a_ack_rise: assert property (@(posedge adc_clk) disable iff (top_rst)
    $rose(ack_o) |-> $past(req_i)) else $error("ack_o rose without req_i");

  // released request closes the cycle on the next edge
  a_ack_fall: assert property (@(posedge adc_clk) disable iff (top_rst)
    (ack_o && !req_i) |=> !ack_o) else $error("ack_o held after req_i dropped");

  // held low under reset
  a_ack_rst: assert property (@(posedge adc_clk) top_rst |-> !ack_o)
    else $error("ack_o high during reset");

endmodule

bind cal_regs cal_regs_sva sva_i (.adc_clk, .top_rst, .req_i, .ack_o);

`default_nettype wire

/* filelist.f */
design/cal_pkg.sv
design/cal_cfg_if.sv
design/cal_regs.sv
design/linear_cal.sv
design/adc_front.sv
design/dac_back.sv
design/analog_top.sv
dv/cal_regs_sva.sv
dv/analog_tb.sv

/* run.sh */
#!/bin/sh
# build and run the calibration testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module analog_tb -f filelist.f -o analog_sim &&
./obj_dir/analog_sim || { echo "simulation failed"; exit 1; }
